//--- Bender.yml
package:
  name: store_queue

sources:
  - rtl/sq_pkg.sv
  - rtl/sq_alloc_ctrl.sv
  - rtl/sq_entry_array.sv
  - rtl/sq_commit_ctrl.sv
  - rtl/sq_fwd_unit.sv
  - rtl/store_queue.sv
  - target: simulation
    files:
      - dv/store_queue_assertions.sv
      - dv/tb_store_queue.sv

//--- dv/store_queue_assertions.sv
module store_queue_assertions (
   input logic             clk,
   input logic             rst,
   input logic             i_str_grant,
   input logic             o_str_req,
   input logic             o_str_iss,
   input logic             o_fwd,
   input sq_pkg::sq_data_t o_fwd_data
);
   timeunit 1ns;
   timeprecision 1ps;

   a_iss_needs_grant: assert property (
      @(posedge clk) disable iff (!rst) o_str_iss |-> i_str_grant
   ) else $error("store issued without a grant");

   a_req_iss_excl: assert property (
      @(posedge clk) disable iff (!rst) !(o_str_req && o_str_iss)
   ) else $error("request and issue high in the same cycle");

   // no match means nothing is driven on the data
   a_fwd_data_zero: assert property (
      @(posedge clk) disable iff (!rst) !o_fwd |-> (o_fwd_data == '0)
   ) else $error("forward data nonzero without a match");

   a_quiet_after_reset: assert property (
      @(posedge clk) $rose(rst) |-> (!o_str_req && !o_str_iss)
   ) else $error("memory strobe high right after reset");

endmodule

bind store_queue store_queue_assertions u_store_queue_assertions (
   .clk         (clk),
   .rst         (rst),
   .i_str_grant (i_str_grant),
   .o_str_req   (o_str_req),
   .o_str_iss   (o_str_iss),
   .o_fwd       (o_fwd),
   .o_fwd_data  (o_fwd_data)
);

//--- dv/tb_store_queue.sv
module tb_store_queue;
   timeunit 1ns;
   timeprecision 1ps;
   import sq_pkg::*;

   typedef enum {OP_ALLOC, OP_UPD, OP_FLUSH, OP_COMMIT, OP_PROBE} op_e;

   // addr and data hold the load address and forward data of a probe
   // or o_addr and o_data at issue for a commit
   typedef struct {
      op_e      op;
      logic [3:0] vld;
      sq_tag_t  tag;   // first alloc tag, update key, load tag or flush pointer
      sq_addr_t addr;
      sq_data_t data;
      logic     fwd;
      logic     rdy;
      logic     stall;
      int       n_gnt;
      int       n_done;
   } row_t;

   localparam int N_ROWS    = 28;
   localparam int RST_CYC   = 2;
   localparam int MAX_CYCLE = N_ROWS * 24 + RST_CYC;

   logic                   clk;
   logic                   rst;
   logic [ALLOC_WIDTH-1:0] i_alloc_vld;
   sq_tag_t                i_alloc_tag [ALLOC_WIDTH];
   logic                   i_upd_vld;
   sq_upd_tag_t            i_upd_tag;
   sq_addr_t               i_upd_addr;
   sq_data_t               i_upd_data;
   logic                   i_flush;
   sq_ptr_t                i_flush_ptr;
   logic                   i_cmmt_str;
   logic                   i_str_grant;
   logic                   i_done;
   sq_tag_t                i_ld_tag;
   sq_addr_t               i_ld_addr;
   logic                   o_stall;
   logic                   o_str_req;
   logic                   o_str_iss;
   sq_addr_t               o_addr;
   sq_data_t               o_data;
   logic                   o_fwd;
   sq_data_t               o_fwd_data;
   logic                   o_fwd_rdy;
   row_t                   rows [N_ROWS];
   int                     cycles;

   store_queue i_store_queue (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles >= MAX_CYCLE) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Done: errors found");
            $fatal(1, "timeout");
         end
      end
   end

   task automatic report_error(string msg);
      $display("FAILED %0t %s", $time, msg);
      $display("Done: errors found");
      $fatal(1, "mismatch");
   endtask

   task automatic check_data(string what, sq_data_t got, sq_data_t exp);
      if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_addr(string what, sq_addr_t got, sq_addr_t exp);
      if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_bit(string what, logic got, logic exp);
      if (got !== exp) report_error($sformatf("%s got %b expected %b", what, got, exp));
   endtask

   task automatic run_commit(row_t r);
      @(posedge clk);
      i_cmmt_str <= 1'b1;
      @(posedge clk);
      i_cmmt_str <= 1'b0;
      @(negedge clk);
      while (o_str_req !== 1'b1) @(negedge clk);
      repeat (r.n_gnt) begin
         @(negedge clk);
         check_bit("o_str_req held", o_str_req, 1'b1);
      end
      @(posedge clk);
      i_str_grant <= 1'b1;
      @(negedge clk);
      check_bit("o_str_iss at grant", o_str_iss, 1'b1);
      check_bit("o_str_req at grant", o_str_req, 1'b0);
      check_addr("o_addr", o_addr, r.addr);
      check_data("o_data", o_data, r.data);
      @(posedge clk);
      i_str_grant <= 1'b0;
      @(negedge clk);
      check_bit("o_str_iss after grant", o_str_iss, 1'b0);
      check_bit("o_str_req after grant", o_str_req, 1'b0);
      repeat (r.n_done) @(posedge clk);
      @(posedge clk);
      i_done <= 1'b1;
      @(posedge clk);
      i_done <= 1'b0;
   endtask

   task automatic apply_row(row_t r);
      case (r.op)
         OP_ALLOC: begin
            @(posedge clk);
            i_alloc_vld <= r.vld;
            for (int k = 0; k < ALLOC_WIDTH; k++) i_alloc_tag[k] <= r.tag + sq_tag_t'(k);
            @(posedge clk);
            i_alloc_vld <= '0;
         end
         OP_UPD: begin
            @(posedge clk);
            i_upd_vld  <= 1'b1;
            i_upd_tag  <= r.tag[5:0];
            i_upd_addr <= r.addr;
            i_upd_data <= r.data;
            @(posedge clk);
            i_upd_vld <= 1'b0;
         end
         OP_FLUSH: begin
            @(posedge clk);
            i_flush     <= 1'b1;
            i_flush_ptr <= r.tag[3:0];
            @(posedge clk);
            i_flush <= 1'b0;
         end
         OP_COMMIT: run_commit(r);
         default: begin  // probe is combinational
            @(posedge clk);
            i_ld_tag  <= r.tag;
            i_ld_addr <= r.addr;
            @(negedge clk);
            check_bit("o_fwd", o_fwd, r.fwd);
            check_data("o_fwd_data", o_fwd_data, r.data);
            check_bit("o_fwd_rdy", o_fwd_rdy, r.rdy);
            check_bit("o_stall", o_stall, r.stall);
         end
      endcase
   endtask

   initial begin
      rows = '{
         '{OP_PROBE,  4'h0, 7'd0,  16'h0000, 16'h0000, 1'b0, 1'b1, 1'b0, 0, 0},
         '{OP_ALLOC,  4'hf, 7'd1,  16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_ALLOC,  4'h7, 7'd5,  16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_UPD,    4'h0, 7'd1,  16'h0100, 16'h1111, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_UPD,    4'h0, 7'd2,  16'h0200, 16'h2222, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_UPD,    4'h0, 7'd3,  16'h0100, 16'h3333, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_UPD,    4'h0, 7'd4,  16'h0300, 16'h4444, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_UPD,    4'h0, 7'd5,  16'h0100, 16'h5555, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_UPD,    4'h0, 7'd6,  16'h0400, 16'h6666, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_UPD,    4'h0, 7'd7,  16'h0500, 16'h7777, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_PROBE,  4'h0, 7'd8,  16'h0100, 16'h5555, 1'b1, 1'b1, 1'b0, 0, 0},
         '{OP_PROBE,  4'h0, 7'd4,  16'h0100, 16'h3333, 1'b1, 1'b1, 1'b0, 0, 0},
         '{OP_PROBE,  4'h0, 7'd1,  16'h0100, 16'h0000, 1'b0, 1'b1, 1'b0, 0, 0},
         '{OP_FLUSH,  4'h0, 7'd5,  16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_PROBE,  4'h0, 7'd8,  16'h0400, 16'h0000, 1'b0, 1'b1, 1'b0, 0, 0},
         '{OP_ALLOC,  4'h3, 7'd8,  16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_PROBE,  4'h0, 7'd10, 16'h0100, 16'h5555, 1'b1, 1'b0, 1'b0, 0, 0},
         '{OP_UPD,    4'h0, 7'd8,  16'h0600, 16'h8888, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_UPD,    4'h0, 7'd9,  16'h0100, 16'h9999, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_PROBE,  4'h0, 7'd10, 16'h0100, 16'h9999, 1'b1, 1'b1, 1'b0, 0, 0},
         '{OP_COMMIT, 4'h0, 7'd0,  16'h0100, 16'h1111, 1'b0, 1'b0, 1'b0, 3, 2},
         '{OP_PROBE,  4'h0, 7'd2,  16'h0100, 16'h0000, 1'b0, 1'b1, 1'b0, 0, 0},
         '{OP_COMMIT, 4'h0, 7'd0,  16'h0200, 16'h2222, 1'b0, 1'b0, 1'b0, 0, 5},
         '{OP_ALLOC,  4'hf, 7'd10, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_ALLOC,  4'h7, 7'd14, 16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0, 0, 0},
         '{OP_PROBE,  4'h0, 7'd0,  16'h0000, 16'h0000, 1'b0, 1'b1, 1'b1, 0, 0},
         '{OP_COMMIT, 4'h0, 7'd0,  16'h0100, 16'h3333, 1'b0, 1'b0, 1'b0, 1, 1},
         '{OP_PROBE,  4'h0, 7'd0,  16'h0000, 16'h0000, 1'b0, 1'b1, 1'b0, 0, 0}
      };
      rst         = 1'b0;
      i_alloc_vld = '0;
      for (int k = 0; k < ALLOC_WIDTH; k++) i_alloc_tag[k] = '0;
      i_upd_vld   = 1'b0;
      i_upd_tag   = '0;
      i_upd_addr  = '0;
      i_upd_data  = '0;
      i_flush     = 1'b0;
      i_flush_ptr = '0;
      i_cmmt_str  = 1'b0;
      i_str_grant = 1'b0;
      i_done      = 1'b0;
      i_ld_tag    = '0;
      i_ld_addr   = '0;
      repeat (RST_CYC) @(posedge clk);
      rst <= 1'b1;
      @(negedge clk);
      check_bit("o_str_req after reset", o_str_req, 1'b0);
      check_bit("o_str_iss after reset", o_str_iss, 1'b0);
      for (int i = 0; i < N_ROWS; i++) apply_row(rows[i]);
      $display("Done: no errors");
      $finish;
   end

endmodule

//--- rtl/sq_alloc_ctrl.sv
module sq_alloc_ctrl (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [sq_pkg::ALLOC_WIDTH-1:0] i_alloc_vld,
   input  logic                           i_flush,
   input  sq_pkg::sq_ptr_t                i_flush_ptr,
   input  sq_pkg::sq_mask_t               i_free_mask,
   output sq_pkg::sq_mask_t               o_slot_mask [sq_pkg::ALLOC_WIDTH],
   output sq_pkg::sq_mask_t               o_flush_mask,
   output logic                           o_stall
);
   import sq_pkg::*;

   localparam int CNT_W = $clog2(ALLOC_WIDTH + 1);

   sq_ptr_t            tail_q;
   sq_ptr_t            nxt_tail;
   sq_ptr_t            stall_idx;
   sq_ptr_t            flush_dist;
   logic [CNT_W-1:0]   run_len;
   logic [CNT_W-1:0]   alloc_cnt;
   sq_mask_t           flush_run;

   // length of the valid run starting at slot 0
   always_comb begin
      logic in_run;
      in_run  = 1'b1;
      run_len = '0;
      for (int k = 0; k < ALLOC_WIDTH; k++) begin
         if (in_run && i_alloc_vld[k]) begin
            run_len = CNT_W'(k + 1);
         end else begin
            in_run = 1'b0;
         end
      end
   end

   // a gap in the valid bits drops the whole group
   assign alloc_cnt = (i_alloc_vld == ALLOC_WIDTH'((1 << run_len) - 1)) ? run_len : '0;
   assign nxt_tail  = tail_q + sq_ptr_t'(alloc_cnt);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         tail_q <= '0;
      end else if (i_flush) begin
         tail_q <= i_flush_ptr;
      end else begin
         tail_q <= nxt_tail;
      end
   end

   always_comb begin
      for (int k = 0; k < ALLOC_WIDTH; k++) begin
         if (k < alloc_cnt) begin
            o_slot_mask[k] = rot_left(sq_mask_t'(1) << k, tail_q);
         end else begin
            o_slot_mask[k] = '0;
         end
      end
   end

   // entries from the flush pointer up to the next tail
   assign flush_dist = nxt_tail - i_flush_ptr;
   assign flush_run  = (sq_mask_t'(1) << flush_dist) - 1'b1;

   assign o_flush_mask = i_flush ? rot_left(flush_run, i_flush_ptr) : '0;

   assign stall_idx = tail_q + sq_ptr_t'(STALL_AHEAD);
   assign o_stall   = !i_free_mask[stall_idx];  // ring about to wrap onto busy entry

endmodule

//--- rtl/sq_commit_ctrl.sv
module sq_commit_ctrl (
   input  logic            clk,
   input  logic            rst,
   input  logic            i_cmmt_str,
   input  logic            i_head_rdy,
   input  logic            i_str_grant,
   input  logic            i_done,
   output sq_pkg::sq_ptr_t o_head,
   output logic            o_retire,
   output logic            o_str_req,
   output logic            o_str_iss
);
   import sq_pkg::*;

   commit_state_e state_q;
   commit_state_e state_nxt;
   sq_ptr_t       head_q;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         IDLE: begin
            if (i_cmmt_str) begin
               state_nxt = i_head_rdy ? WAIT_GRANT : WAIT_READY;
            end
         end
         WAIT_READY: begin
            if (i_head_rdy) state_nxt = WAIT_GRANT;  // address arrived
         end
         WAIT_GRANT: begin
            if (i_str_grant) state_nxt = ISSUED;
         end
         ISSUED: begin
            if (i_done) state_nxt = IDLE;
         end
         default: state_nxt = IDLE;
      endcase
   end

   // request held until grant, issue pulses in the grant cycle
   assign o_str_req = (state_q == WAIT_GRANT) && !i_str_grant;
   assign o_str_iss = (state_q == WAIT_GRANT) && i_str_grant;
   assign o_retire  = (state_q == ISSUED) && i_done;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         head_q <= '0;
      end else if (o_retire) begin
         head_q <= head_q + 1'b1;
      end
   end

   assign o_head = head_q;

endmodule

//--- rtl/sq_entry_array.sv
module sq_entry_array (
   input  logic                clk,
   input  logic                rst,
   input  sq_pkg::sq_mask_t    i_slot_mask [sq_pkg::ALLOC_WIDTH],
   input  sq_pkg::sq_tag_t     i_alloc_tag [sq_pkg::ALLOC_WIDTH],
   input  logic                i_upd_vld,
   input  sq_pkg::sq_upd_tag_t i_upd_tag,
   input  sq_pkg::sq_addr_t    i_upd_addr,
   input  sq_pkg::sq_data_t    i_upd_data,
   input  sq_pkg::sq_mask_t    i_flush_mask,
   input  logic                i_retire,
   input  sq_pkg::sq_ptr_t     i_head,
   output sq_pkg::sq_mask_t    o_free_mask,
   output sq_pkg::sq_mask_t    o_addr_rdy_mask,
   output sq_pkg::sq_tag_t     o_tags  [sq_pkg::SQ_DEPTH],
   output sq_pkg::sq_addr_t    o_addrs [sq_pkg::SQ_DEPTH],
   output sq_pkg::sq_data_t    o_datas [sq_pkg::SQ_DEPTH],
   output logic                o_head_rdy,
   output sq_pkg::sq_addr_t    o_head_addr,
   output sq_pkg::sq_data_t    o_head_data
);
   import sq_pkg::*;

   sq_mask_t free_q;
   sq_mask_t addr_rdy_q;
   sq_mask_t alloc_mask;
   sq_mask_t ret_mask;
   sq_mask_t upd_hit;
   sq_tag_t  tags_q  [SQ_DEPTH];
   sq_addr_t addrs_q [SQ_DEPTH];
   sq_data_t datas_q [SQ_DEPTH];

   always_comb begin
      alloc_mask = '0;
      for (int k = 0; k < ALLOC_WIDTH; k++) begin
         alloc_mask |= i_slot_mask[k];
      end
   end

   assign ret_mask = i_retire ? (sq_mask_t'(1) << i_head) : '0;

   // update is keyed by the low tag bits of busy entries
   always_comb begin
      for (int i = 0; i < SQ_DEPTH; i++) begin
         upd_hit[i] = i_upd_vld && !free_q[i] &&
                      (tags_q[i][$bits(sq_upd_tag_t)-1:0] == i_upd_tag);
      end
   end

   // flush and retire both win over allocation
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         free_q     <= '1;
         addr_rdy_q <= '0;
      end else begin
         free_q     <= (free_q & ~alloc_mask) | ret_mask | i_flush_mask;
         addr_rdy_q <= (addr_rdy_q | upd_hit) & ~(ret_mask | i_flush_mask);
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < SQ_DEPTH; i++) begin
         if (upd_hit[i]) begin
            addrs_q[i] <= i_upd_addr;
            datas_q[i] <= i_upd_data;
         end
         if (i_flush_mask[i]) begin
            tags_q[i] <= '0;
         end else begin
            for (int k = 0; k < ALLOC_WIDTH; k++) begin
               if (i_slot_mask[k][i]) tags_q[i] <= i_alloc_tag[k];
            end
         end
      end
   end

   assign o_free_mask     = free_q;
   assign o_addr_rdy_mask = addr_rdy_q;
   assign o_tags          = tags_q;
   assign o_addrs         = addrs_q;
   assign o_datas         = datas_q;

   assign o_head_rdy  = addr_rdy_q[i_head];
   assign o_head_addr = addrs_q[i_head];
   assign o_head_data = datas_q[i_head];

endmodule

//--- rtl/sq_fwd_unit.sv
module sq_fwd_unit (
   input  sq_pkg::sq_tag_t  i_ld_tag,
   input  sq_pkg::sq_addr_t i_ld_addr,
   input  sq_pkg::sq_ptr_t  i_head,
   input  sq_pkg::sq_mask_t i_free_mask,
   input  sq_pkg::sq_mask_t i_addr_rdy_mask,
   input  sq_pkg::sq_tag_t  i_tags  [sq_pkg::SQ_DEPTH],
   input  sq_pkg::sq_addr_t i_addrs [sq_pkg::SQ_DEPTH],
   input  sq_pkg::sq_data_t i_datas [sq_pkg::SQ_DEPTH],
   output logic             o_fwd,
   output sq_pkg::sq_data_t o_fwd_data,
   output logic             o_fwd_rdy
);
   import sq_pkg::*;

   sq_mask_t older;     // store precedes the load
   sq_mask_t addr_eq;
   sq_mask_t match;
   sq_mask_t match_rot; // bit 0 is the head entry
   sq_mask_t ready;
   sq_ptr_t  fwd_pos;
   sq_ptr_t  fwd_idx;

   always_comb begin
      for (int i = 0; i < SQ_DEPTH; i++) begin
         older[i]   = i_ld_tag > i_tags[i];
         addr_eq[i] = i_ld_addr == i_addrs[i];
      end
   end

   assign match = ~i_free_mask & older & addr_eq;

   // a free, resolved or younger entry cannot block the load
   assign ready     = i_free_mask | i_addr_rdy_mask | ~older;
   assign o_fwd_rdy = &ready;

   assign match_rot = rot_right(match, i_head);

   // furthest from the head is the youngest matching store
   always_comb begin
      fwd_pos = '0;
      for (int p = 0; p < SQ_DEPTH; p++) begin
         if (match_rot[p]) fwd_pos = sq_ptr_t'(p);
      end
   end

   assign fwd_idx = i_head + fwd_pos;

   assign o_fwd      = |match;
   assign o_fwd_data = o_fwd ? i_datas[fwd_idx] : '0;

endmodule

//--- rtl/sq_pkg.sv
package sq_pkg;

   localparam int SQ_DEPTH    = 16;
   localparam int ALLOC_WIDTH = 4;  // stores allocated per cycle
   localparam int STALL_AHEAD = 4;  // stall looks this far past the tail

   typedef logic [$clog2(SQ_DEPTH)-1:0] sq_ptr_t;
   typedef logic [SQ_DEPTH-1:0]         sq_mask_t;
   typedef logic [15:0]                 sq_data_t;
   typedef logic [15:0]                 sq_addr_t;
   typedef logic [6:0]                  sq_tag_t;
   typedef logic [5:0]                  sq_upd_tag_t;  // low bits of sq_tag_t

   typedef enum logic [1:0] {
      IDLE,
      WAIT_READY,  // head store still missing its address
      WAIT_GRANT,
      ISSUED
   } commit_state_e;

   // ring rotation toward higher entry numbers
   function automatic sq_mask_t rot_left(sq_mask_t m, sq_ptr_t n);
      logic [2*SQ_DEPTH-1:0] d;
      d = {m, m} << n;
      return d[2*SQ_DEPTH-1 -: SQ_DEPTH];
   endfunction

   // ring rotation toward entry 0
   function automatic sq_mask_t rot_right(sq_mask_t m, sq_ptr_t n);
      logic [2*SQ_DEPTH-1:0] d;
      d = {m, m} >> n;
      return d[SQ_DEPTH-1:0];
   endfunction

endpackage

//--- rtl/store_queue.sv
module store_queue (
   input  logic                                      clk,
   input  logic                                      rst,
   input  logic [sq_pkg::ALLOC_WIDTH-1:0]            i_alloc_vld,
   input  sq_pkg::sq_tag_t                           i_alloc_tag [sq_pkg::ALLOC_WIDTH],
   input  logic                                      i_upd_vld,
   input  sq_pkg::sq_upd_tag_t                       i_upd_tag,
   input  sq_pkg::sq_addr_t                          i_upd_addr,
   input  sq_pkg::sq_data_t                          i_upd_data,
   input  logic                                      i_flush,
   input  sq_pkg::sq_ptr_t                           i_flush_ptr,
   input  logic                                      i_cmmt_str,
   input  logic                                      i_str_grant,
   input  logic                                      i_done,
   input  sq_pkg::sq_tag_t                           i_ld_tag,
   input  sq_pkg::sq_addr_t                          i_ld_addr,
   output logic                                      o_stall,
   output logic                                      o_str_req,
   output logic                                      o_str_iss,
   output sq_pkg::sq_addr_t                          o_addr,
   output sq_pkg::sq_data_t                          o_data,
   output logic                                      o_fwd,
   output sq_pkg::sq_data_t                          o_fwd_data,
   output logic                                      o_fwd_rdy
);
   import sq_pkg::*;

   sq_mask_t slot_mask [ALLOC_WIDTH];  // one-hot target entry per slot
   sq_mask_t flush_mask;
   sq_mask_t free_mask;
   sq_mask_t addr_rdy_mask;
   sq_tag_t  tags  [SQ_DEPTH];
   sq_addr_t addrs [SQ_DEPTH];
   sq_data_t datas [SQ_DEPTH];
   sq_ptr_t  head;
   logic     retire;
   logic     head_rdy;

   sq_alloc_ctrl u_alloc_ctrl (
      .clk          (clk),
      .rst          (rst),
      .i_alloc_vld  (i_alloc_vld),
      .i_flush      (i_flush),
      .i_flush_ptr  (i_flush_ptr),
      .i_free_mask  (free_mask),
      .o_slot_mask  (slot_mask),
      .o_flush_mask (flush_mask),
      .o_stall      (o_stall)
   );

   sq_entry_array u_entry_array (
      .clk             (clk),
      .rst             (rst),
      .i_slot_mask     (slot_mask),
      .i_alloc_tag     (i_alloc_tag),
      .i_upd_vld       (i_upd_vld),
      .i_upd_tag       (i_upd_tag),
      .i_upd_addr      (i_upd_addr),
      .i_upd_data      (i_upd_data),
      .i_flush_mask    (flush_mask),
      .i_retire        (retire),
      .i_head          (head),
      .o_free_mask     (free_mask),
      .o_addr_rdy_mask (addr_rdy_mask),
      .o_tags          (tags),
      .o_addrs         (addrs),
      .o_datas         (datas),
      .o_head_rdy      (head_rdy),
      .o_head_addr     (o_addr),
      .o_head_data     (o_data)
   );

   sq_commit_ctrl u_commit_ctrl (
      .clk         (clk),
      .rst         (rst),
      .i_cmmt_str  (i_cmmt_str),
      .i_head_rdy  (head_rdy),
      .i_str_grant (i_str_grant),
      .i_done      (i_done),
      .o_head      (head),
      .o_retire    (retire),
      .o_str_req   (o_str_req),
      .o_str_iss   (o_str_iss)
   );

   sq_fwd_unit u_fwd_unit (
      .i_ld_tag        (i_ld_tag),
      .i_ld_addr       (i_ld_addr),
      .i_head          (head),
      .i_free_mask     (free_mask),
      .i_addr_rdy_mask (addr_rdy_mask),
      .i_tags          (tags),
      .i_addrs         (addrs),
      .i_datas         (datas),
      .o_fwd           (o_fwd),
      .o_fwd_data      (o_fwd_data),
      .o_fwd_rdy       (o_fwd_rdy)
   );

endmodule

//--- store_queue.f
rtl/sq_pkg.sv
rtl/sq_alloc_ctrl.sv
rtl/sq_entry_array.sv
rtl/sq_commit_ctrl.sv
rtl/sq_fwd_unit.sv
rtl/store_queue.sv
dv/store_queue_assertions.sv
dv/tb_store_queue.sv
